//--- hdl/i2c_settings.svh
// ********************
// i2c settings: bus timing and
// serial EEPROM constants
// ********************
`ifndef I2C_SETTINGS_SVH
`define I2C_SETTINGS_SVH

// clk_sys cycles per quarter scl period
// 8 keeps simulation short, about 16 gives ~780 kHz at 50 MHz
`define I2C_QUARTER 8

// quarter counter width, room for up to 31
`define I2C_QCNT_W 5

// 24LC64 with A2..A0 tied low
`define EEPROM_DEV_ADDR 7'b1010000

`endif

//--- hdl/i2c_pkg.sv
// ********************
// i2c package: states, opcodes and
// the structs passed between blocks
// ********************
package i2c_pkg;

    localparam int BYTE_BITS = 8;

    // transaction sequence, one state per bus phase
    typedef enum logic [4:0] {
        ST_IDLE,
        ST_START,
        ST_CTRL,
        ST_ADDR_HI,
        ST_ADDR_LO,
        ST_WDATA,
        ST_RESTART,
        ST_CTRL_RD,
        ST_RDATA,
        ST_NOACK,
        ST_STOP,
        ST_RELEASE
    } i2c_state_e;

    // doubles as the r/w bit of the control byte
    typedef enum logic {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } i2c_op_e;

    typedef struct packed {
        logic low_mid;
        logic high_mid;
    } scl_tick_t;

    typedef struct packed {
        logic                 load;
        logic [BYTE_BITS-1:0] load_byte;
        logic                 shift;
        logic                 capture;
        logic                 commit;
    } shift_ctl_t;

    typedef struct packed {
        logic oe;
        logic out;
    } sda_drive_t;

endpackage

//--- hdl/scl_timer.sv
// ********************
// scl timer: quarter-bit counter making scl
// and the mid-low / mid-high strobes
// ********************
`include "i2c_settings.svh"

module scl_timer
    import i2c_pkg::*;
(
    input  logic      clk_sys,
    input  logic      rst_n,
    input  logic      run,
    output logic      scl,
    output scl_tick_t tick
);

    localparam int QW = `I2C_QCNT_W;
    localparam logic [QW-1:0] Q_LAST = QW'(`I2C_QUARTER - 1);

    logic [QW-1:0] q_cnt;
    logic [1:0]    phase;
    logic [1:0]    phase_nxt;
    logic          q_wrap;

    // end of a quarter
    assign q_wrap = run && (q_cnt == Q_LAST);

    // phases 0,1 low, 2,3 high; parked at 0 while idle
    assign phase_nxt = !run ? 2'd0 : (q_wrap ? phase + 2'd1 : phase);

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            q_cnt <= '0;
            phase <= 2'd0;
            scl   <= 1'b1;
            tick  <= '0;
        end else begin
            // registered so scl never glitches on a state change
            scl   <= ~run | phase_nxt[1];
            phase <= phase_nxt;
            // strobes on entry to phase 1 and phase 3
            tick.low_mid  <= q_wrap && (phase == 2'd0);
            tick.high_mid <= q_wrap && (phase == 2'd2);
            if (!run || q_wrap) begin
                q_cnt <= '0;
            end else begin
                q_cnt <= q_cnt + 1'b1;
            end
        end
    end

endmodule

//--- hdl/byte_shifter.sv
// ********************
// byte shifter: parallel load, msb-first
// transmit and receive, result register
// ********************
module byte_shifter
    import i2c_pkg::*;
(
    input  logic       clk_sys,
    input  logic       rst_n,
    input  shift_ctl_t ctl,
    input  logic       sda_in,
    output logic       tx_bit,
    output logic [7:0] result
);

    logic [BYTE_BITS-1:0] shreg;
    logic [BYTE_BITS-1:0] rx_next;

    // byte after taking in the current bus bit
    assign rx_next = {shreg[BYTE_BITS-2:0], sda_in};

    // msb goes out first
    assign tx_bit = shreg[BYTE_BITS-1];

    always_ff @(posedge clk_sys) begin
        if (ctl.load) begin
            shreg <= ctl.load_byte;
        end else if (ctl.shift) begin
            shreg <= {shreg[BYTE_BITS-2:0], 1'b0};
        end else if (ctl.capture) begin
            shreg <= rx_next;
        end
    end

    // commit rides with the last capture
    // so take the byte including this bit
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
        end else if (ctl.commit) begin
            result <= rx_next;
        end
    end

endmodule

//--- hdl/i2c_fsm.sv
// ********************
// i2c fsm: key request latch and the
// random byte write / read sequence
// ********************
`include "i2c_settings.svh"

module i2c_fsm
    import i2c_pkg::*;
(
    input  logic        clk_sys,
    input  logic        rst_n,
    input  logic        key_wr,
    input  logic        key_rd,
    input  logic [15:0] mem_addr,
    input  logic [7:0]  wr_data,
    input  scl_tick_t   tick,
    input  logic        tx_bit,
    input  logic        sda_in,
    output logic        run,
    output logic        busy,
    output logic        led,
    output shift_ctl_t  ctl,
    output sda_drive_t  drive
);

    localparam logic [7:0] CTRL_WR  = {`EEPROM_DEV_ADDR, OP_WRITE};
    localparam logic [7:0] CTRL_RD  = {`EEPROM_DEV_ADDR, OP_READ};
    localparam logic [3:0] ACK_BIT  = 4'(BYTE_BITS);
    localparam logic [3:0] LAST_BIT = 4'(BYTE_BITS - 1);

    i2c_state_e  state;
    i2c_op_e     op;
    logic [3:0]  bit_cnt;
    logic        req_wr;
    logic        req_rd;
    logic        wr_pend;
    logic        rd_pend;
    logic        clr_wr;
    logic        clr_rd;
    logic        ack_slot;
    logic        tx_state;
    logic [15:0] addr_q;
    logic [7:0]  data_q;

    // byte that follows a transmitted byte and its ack
    function automatic i2c_state_e after_byte(input i2c_state_e s, input i2c_op_e o);
        case (s)
            ST_CTRL:    return ST_ADDR_HI;
            ST_ADDR_HI: return ST_ADDR_LO;
            ST_ADDR_LO: return (o == OP_WRITE) ? ST_WDATA : ST_RESTART;
            ST_CTRL_RD: return ST_RDATA;
            default:    return ST_STOP;
        endcase
    endfunction

    assign wr_pend  = req_wr | ~key_wr;
    assign rd_pend  = req_rd | ~key_rd;
    assign ack_slot = (bit_cnt == ACK_BIT);
    assign tx_state = state inside {ST_CTRL, ST_ADDR_HI, ST_ADDR_LO, ST_WDATA, ST_CTRL_RD};
    assign run      = (state != ST_IDLE) && (state != ST_RELEASE);
    assign busy     = (state != ST_IDLE);

    // write request drops only once both keys are up
    assign clr_wr = (state == ST_RELEASE) && key_wr && key_rd;
    assign clr_rd = (state == ST_STOP) && tick.high_mid && (op == OP_READ);

    // keys are active low, held until served
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            req_wr <= 1'b0;
            req_rd <= 1'b0;
        end else begin
            req_wr <= wr_pend & ~clr_wr;
            req_rd <= rd_pend & ~clr_rd;
        end
    end

    // address and data follow the inputs until the request starts
    always_ff @(posedge clk_sys) begin
        if (state == ST_IDLE) begin
            addr_q <= mem_addr;
            data_q <= wr_data;
        end
    end

    // shifter commands, acted on one cycle later
    always_comb begin
        ctl = '0;
        case (state)
            ST_START: begin
                ctl.load      = tick.high_mid;
                ctl.load_byte = CTRL_WR;
            end
            ST_RESTART: begin
                ctl.load      = tick.high_mid;
                ctl.load_byte = CTRL_RD;
            end
            ST_CTRL: begin
                ctl.load      = tick.high_mid && ack_slot;
                ctl.load_byte = addr_q[15:8];
            end
            ST_ADDR_HI: begin
                ctl.load      = tick.high_mid && ack_slot;
                ctl.load_byte = addr_q[7:0];
            end
            ST_ADDR_LO: begin
                // read turns to the restart instead
                ctl.load      = tick.high_mid && ack_slot && (op == OP_WRITE);
                ctl.load_byte = data_q;
            end
            ST_RDATA: begin
                ctl.capture = tick.high_mid;
                ctl.commit  = tick.high_mid && (bit_cnt == LAST_BIT);
            end
            default: begin
            end
        endcase
        ctl.shift = tx_state && tick.low_mid && !ack_slot;
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            op      <= OP_WRITE;
            bit_cnt <= '0;
            drive   <= '{oe: 1'b1, out: 1'b1};
            led     <= 1'b1;
        end else begin
            case (state)
                ST_IDLE: begin
                    drive   <= '{oe: 1'b1, out: 1'b1};
                    bit_cnt <= '0;
                    // start only from a free line, write wins
                    if ((wr_pend || rd_pend) && sda_in) begin
                        op    <= wr_pend ? OP_WRITE : OP_READ;
                        state <= ST_START;
                    end
                end
                ST_START: begin
                    // sda falls with scl high
                    if (tick.high_mid) begin
                        drive.out <= 1'b0;
                        state     <= ST_CTRL;
                    end
                end
                ST_CTRL, ST_ADDR_HI, ST_ADDR_LO, ST_WDATA, ST_CTRL_RD: begin
                    if (tick.low_mid) begin
                        // data bits from the shifter, ack slot released
                        if (ack_slot) begin
                            drive.oe <= 1'b0;
                        end else begin
                            drive <= '{oe: 1'b1, out: tx_bit};
                        end
                    end
                    if (tick.high_mid) begin
                        if (ack_slot) begin
                            bit_cnt <= '0;
                            state   <= after_byte(state, op);
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                ST_RDATA: begin
                    if (tick.low_mid) begin
                        drive.oe <= 1'b0;
                    end
                    if (tick.high_mid) begin
                        if (bit_cnt == LAST_BIT) begin
                            bit_cnt <= '0;
                            state   <= ST_NOACK;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                ST_NOACK: begin
                    // sda held high ends the read
                    if (tick.low_mid) begin
                        drive <= '{oe: 1'b1, out: 1'b1};
                    end
                    if (tick.high_mid) begin
                        state <= ST_STOP;
                    end
                end
                ST_RESTART: begin
                    // raise sda while scl low, drop it while high
                    if (tick.low_mid) begin
                        drive <= '{oe: 1'b1, out: 1'b1};
                    end
                    if (tick.high_mid) begin
                        drive.out <= 1'b0;
                        state     <= ST_CTRL_RD;
                    end
                end
                ST_STOP: begin
                    if (tick.low_mid) begin
                        drive <= '{oe: 1'b1, out: 1'b0};
                    end
                    if (tick.high_mid) begin
                        drive.out <= 1'b1;
                        if (op == OP_WRITE) begin
                            led   <= 1'b0;
                            state <= ST_RELEASE;
                        end else begin
                            state <= ST_IDLE;
                        end
                    end
                end
                ST_RELEASE: begin
                    // hold until keys are up, no repeat write
                    if (key_wr && key_rd) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

//--- hdl/eeprom_ctrl_top.sv
// ********************
// eeprom controller top: timer, shifter,
// fsm and the sda open line
// ********************
module eeprom_ctrl_top (
    input  logic        clk_sys,
    input  logic        rst_n,
    input  logic        key_wr,
    input  logic        key_rd,
    input  logic [15:0] mem_addr,
    input  logic [7:0]  wr_data,
    output logic        scl,
    output logic        busy,
    output logic        led,
    output logic [7:0]  result,
    inout  wire         sda
);

    i2c_pkg::scl_tick_t  tick;
    i2c_pkg::shift_ctl_t ctl;
    i2c_pkg::sda_drive_t drive;
    logic                run;
    logic                tx_bit;
    logic                sda_in;

    // released sda floats to the pull-up
    assign sda    = drive.oe ? drive.out : 1'bz;
    assign sda_in = sda;

    scl_timer scl_timer_i (
        .clk_sys (clk_sys),
        .rst_n   (rst_n),
        .run     (run),
        .scl     (scl),
        .tick    (tick)
    );

    byte_shifter byte_shifter_i (
        .clk_sys (clk_sys),
        .rst_n   (rst_n),
        .ctl     (ctl),
        .sda_in  (sda_in),
        .tx_bit  (tx_bit),
        .result  (result)
    );

    i2c_fsm i2c_fsm_i (
        .clk_sys  (clk_sys),
        .rst_n    (rst_n),
        .key_wr   (key_wr),
        .key_rd   (key_rd),
        .mem_addr (mem_addr),
        .wr_data  (wr_data),
        .tick     (tick),
        .tx_bit   (tx_bit),
        .sda_in   (sda_in),
        .run      (run),
        .busy     (busy),
        .led      (led),
        .ctl      (ctl),
        .drive    (drive)
    );

endmodule

//--- verification/tb_clock_gen.sv
// ********************
// testbench clock and reset source
// ********************
module tb_clock_gen #(
    parameter int PERIOD      = 20,
    parameter int RESET_TICKS = 2
) (
    output logic clk_sys,
    output logic rst_n
);

    initial begin
        clk_sys = 1'b0;
        forever #(PERIOD / 2) clk_sys = ~clk_sys;
    end

    // reset held low for a couple of cycles
    initial begin
        rst_n = 1'b0;
        repeat (RESET_TICKS) @(posedge clk_sys);
        rst_n <= 1'b1;
    end

endmodule

//--- verification/eeprom_model.sv
// ********************
// behavioral i2c eeprom slave, open drain
// acks every byte, serves random reads
// ********************
module eeprom_model #(
    parameter int DRIVE_DLY = 240
) (
    input logic scl,
    inout wire  sda
);

    logic [7:0]  mem [int];
    logic [15:0] ptr;
    logic [7:0]  rx;
    logic [7:0]  tx;
    logic [3:0]  cnt;
    int          byte_idx;
    logic        in_ack;
    logic        rd_mode;
    logic        sending;
    logic        drv_low;

    // only ever pulls low
    assign sda = drv_low ? 1'b0 : 1'bz;

    initial begin
        drv_low  = 1'b0;
        cnt      = '0;
        in_ack   = 1'b0;
        rd_mode  = 1'b0;
        sending  = 1'b0;
        byte_idx = 0;
        ptr      = '0;
        rx       = '0;
        tx       = 8'hff;
    end

    // start or restart
    always @(negedge sda) begin
        if (scl === 1'b1) begin
            cnt      = '0;
            in_ack   = 1'b0;
            rd_mode  = 1'b0;
            sending  = 1'b0;
            byte_idx = 0;
        end
    end

    // stop ends any transfer
    always @(posedge sda) begin
        if (scl === 1'b1) begin
            sending = 1'b0;
            in_ack  = 1'b0;
        end
    end

    always @(posedge scl) begin
        if (in_ack) begin
            // ack slot done, next byte
            in_ack = 1'b0;
            cnt    = '0;
            // a no-ack from the master ends the read
            if (rd_mode && (sda === 1'b0)) begin
                sending = 1'b1;
                tx      = mem.exists(ptr) ? mem[ptr] : 8'hff;
            end else begin
                sending = 1'b0;
            end
        end else if (sending) begin
            cnt = cnt + 1'b1;
            if (cnt == 4'd8) begin
                in_ack = 1'b1;
                ptr    = ptr + 1'b1;
            end
        end else begin
            rx  = {rx[6:0], sda};
            cnt = cnt + 1'b1;
            if (cnt == 4'd8) begin
                in_ack = 1'b1;
                case (byte_idx)
                    0: rd_mode = rx[0];
                    1: ptr[15:8] = rx;
                    2: ptr[7:0] = rx;
                    default: begin
                        mem[ptr] = rx;
                        ptr      = ptr + 1'b1;
                    end
                endcase
                byte_idx++;
            end
        end
    end

    // let go at scl fall, drive once the master has moved off the line
    always @(negedge scl) begin
        drv_low = 1'b0;
        #(DRIVE_DLY);
        if (scl === 1'b0) begin
            if (in_ack && !sending) begin
                drv_low = 1'b1;
            end else if (sending && !in_ack) begin
                drv_low = ~tx[7 - cnt];
            end
        end
    end

endmodule

//--- verification/eeprom_ctrl_properties.sv
// ********************
// bus and status assertions for the
// eeprom controller, bound to the top
// ********************
module eeprom_ctrl_properties
    import i2c_pkg::*;
(
    input logic       clk_sys,
    input logic       rst_n,
    input logic       scl,
    input logic       sda,
    input logic       busy,
    input logic       led,
    input i2c_state_e state
);

    // count of failed assertions
    int n_fail = 0;

    // data only moves while scl is low, start and stop excepted
    sda_stable_high: assert property (@(posedge clk_sys) disable iff (!rst_n)
        (scl && $past(scl) && !($past(state) inside {ST_START, ST_RESTART, ST_STOP}))
        |-> $stable(sda))
        else begin
            n_fail++;
            $error("sda moved while scl high");
        end

    // idle bus keeps scl up
    scl_idle_high: assert property (@(posedge clk_sys) disable iff (!rst_n)
        !busy |-> scl)
        else begin
            n_fail++;
            $error("scl low while idle");
        end

    led_sticky_low: assert property (@(posedge clk_sys) disable iff (!rst_n)
        !led |=> !led)
        else begin
            n_fail++;
            $error("led rose after falling");
        end

endmodule

//--- verification/tb_eeprom_ctrl.sv
// ********************
// eeprom controller testbench: key driven
// writes and reads against a shadow memory
// ********************
`include "i2c_settings.svh"

module tb_eeprom_ctrl;

    localparam int N_TRANS   = 30;
    localparam int CYC_LIMIT = N_TRANS * 50 * 4 * `I2C_QUARTER * 2;

    logic        clk_sys;
    logic        rst_n;
    logic        key_wr;
    logic        key_rd;
    logic [15:0] mem_addr;
    logic [7:0]  wr_data;
    logic        scl;
    logic        busy;
    logic        led;
    logic [7:0]  result;
    wire         sda;

    logic [7:0]  shadow [int];
    logic [31:0] lcg_state;
    logic [15:0] rd_addr;
    logic        rd_pending;
    int          n_checked;
    int          n_writes;
    int          starts;
    int          stops;
    int          cycles;

    // weak pull-up on the open line
    assign (weak0, weak1) sda = 1'b1;

    tb_clock_gen #(.PERIOD(20), .RESET_TICKS(2)) clock_gen_i (
        .clk_sys (clk_sys),
        .rst_n   (rst_n)
    );

    eeprom_ctrl_top eeprom_ctrl_top_i (
        .clk_sys  (clk_sys),
        .rst_n    (rst_n),
        .key_wr   (key_wr),
        .key_rd   (key_rd),
        .mem_addr (mem_addr),
        .wr_data  (wr_data),
        .scl      (scl),
        .busy     (busy),
        .led      (led),
        .result   (result),
        .sda      (sda)
    );

    eeprom_model #(.DRIVE_DLY(20 * `I2C_QUARTER * 3 / 2)) eeprom_model_i (
        .scl (scl),
        .sda (sda)
    );

    bind eeprom_ctrl_top eeprom_ctrl_properties props_i (
        .clk_sys (clk_sys),
        .rst_n   (rst_n),
        .scl     (scl),
        .sda     (sda),
        .busy    (busy),
        .led     (led),
        .state   (i2c_fsm_i.state)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // erased cells read back as ff
    function automatic logic [7:0] ref_read(input logic [15:0] a);
        return shadow.exists(a) ? shadow[a] : 8'hff;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic wait_idle();
        while (busy !== 1'b0) @(posedge clk_sys);
    endtask

    task automatic press_key(input logic is_rd, input logic [15:0] a, input logic [7:0] d);
        @(posedge clk_sys);
        key_wr   <= is_rd;
        key_rd   <= !is_rd;
        mem_addr <= a;
        wr_data  <= d;
        repeat (4) @(posedge clk_sys);
        key_wr <= 1'b1;
        key_rd <= 1'b1;
        if (busy !== 1'b1) begin
            $display("busy did not rise after a key press");
            $display("SOME TESTS FAILED");
            $fatal(1, "no transaction started");
        end
        // led stays high until the first write has finished
        check("led", led, (n_writes == 0) ? 32'd1 : 32'd0);
        wait_idle();
    endtask

    task automatic issue_write(input logic [15:0] a, input logic [7:0] d);
        shadow[a] = d;
        press_key(1'b0, a, d);
        n_writes++;
    endtask

    task automatic issue_read(input logic [15:0] a);
        rd_addr    = a;
        rd_pending = 1'b1;
        press_key(1'b1, a, 8'h00);
    endtask

    // result compared once each read ends
    always @(negedge busy) begin
        if (rd_pending) begin
            check("result", result, ref_read(rd_addr));
            rd_pending = 1'b0;
            n_checked++;
        end
    end

    // bus start and stop counters
    always @(negedge sda) if (scl === 1'b1) starts++;
    always @(posedge sda) if (scl === 1'b1) stops++;

    always @(posedge clk_sys) begin
        cycles++;
        if (eeprom_ctrl_top_i.props_i.n_fail != 0) begin
            $display("a bus or status assertion failed");
            $display("SOME TESTS FAILED");
            $fatal(1, "assertion failure");
        end else if (cycles >= CYC_LIMIT) begin
            $display("run took too many cycles, a transaction never finished");
            $display("SOME TESTS FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        logic [15:0] addr_q [$];
        logic [15:0] a;
        logic [15:0] b;
        logic [7:0]  d;
        int          s0;
        key_wr     = 1'b1;
        key_rd     = 1'b1;
        mem_addr   = '0;
        wr_data    = '0;
        lcg_state  = 32'h0431_0ec4;
        rd_pending = 1'b0;
        n_checked  = 0;
        n_writes   = 0;
        starts     = 0;
        stops      = 0;
        cycles     = 0;
        wait (rst_n === 1'b1);
        @(posedge clk_sys);
        check("busy", busy, 0);
        check("scl", scl, 1);
        check("sda", sda, 1);
        check("led", led, 1);
        check("result", result, 8'h00);
        // directed write then read
        issue_write(16'h0003, 8'h5a);
        check("led", led, 0);
        issue_read(16'h0003);
        check("result", result, 8'h5a);
        // random writes then reads back
        repeat (12) begin
            a = lcg_next();
            d = lcg_next();
            addr_q.push_back(a);
            issue_write(a, d);
        end
        foreach (addr_q[i]) begin
            issue_read(addr_q[i]);
        end
        check("led", led, 0);
        // never written address
        do begin
            a = lcg_next();
        end while (shadow.exists(a));
        issue_read(a);
        check("result", result, 8'hff);
        // write key held past the stop
        a  = lcg_next();
        d  = lcg_next();
        do begin
            b = lcg_next();
        end while (shadow.exists(b) || b == a);
        s0 = starts;
        shadow[a] = d;
        @(posedge clk_sys);
        key_wr   <= 1'b0;
        mem_addr <= a;
        wr_data  <= d;
        while (starts == s0 || busy !== 1'b1) @(posedge clk_sys);
        s0 = stops;
        while (stops == s0) @(posedge clk_sys);
        mem_addr <= b;
        wr_data  <= ~d;
        repeat (20) begin
            @(posedge clk_sys);
            check("busy", busy, 1);
        end
        key_wr <= 1'b1;
        wait_idle();
        repeat (4) @(posedge clk_sys);
        check("busy", busy, 0);
        issue_read(b);
        issue_read(a);
        check("led", led, 0);
        check("n_checked", n_checked, 16);
        if (eeprom_ctrl_top_i.props_i.n_fail == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+hdl
hdl/i2c_pkg.sv
hdl/scl_timer.sv
hdl/byte_shifter.sv
hdl/i2c_fsm.sv
hdl/eeprom_ctrl_top.sv
verification/tb_clock_gen.sv
verification/eeprom_model.sv
verification/eeprom_ctrl_properties.sv
verification/tb_eeprom_ctrl.sv

//--- Bender.yml
package:
  name: eeprom_ctrl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/i2c_pkg.sv
      - hdl/scl_timer.sv
      - hdl/byte_shifter.sv
      - hdl/i2c_fsm.sv
      - hdl/eeprom_ctrl_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verification/tb_clock_gen.sv
      - verification/eeprom_model.sv
      - verification/eeprom_ctrl_properties.sv
      - verification/tb_eeprom_ctrl.sv
